// File: rtl/mhu_pkg.sv
// ==============================
// WAYS, SETS and WORDS_PER_BLOCK must be powers of two, WAYS at least 2
// ==============================
package mhu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W = 4;
  localparam int WAYS = 4;
  localparam int SETS = 16;
  localparam int WORDS_PER_BLOCK = 4;

  // Address splits low to high into byte select, word offset, index, tag
  localparam int BYTE_SEL_W = $clog2(DATA_W / 8);
  localparam int OFFSET_W = $clog2(WORDS_PER_BLOCK);
  localparam int INDEX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - BYTE_SEL_W;
  localparam int WAY_W = $clog2(WAYS);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ID_W-1:0] id_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [WAY_W-1:0] way_t;
  typedef logic [WAYS-1:0] way_mask_t;
  typedef logic [WAYS-2:0] lru_t;
  typedef logic [OFFSET_W-1:0] word_off_t;

  typedef enum logic [1:0] {
    TAG_OP_IDLE,
    TAG_OP_READ,
    TAG_OP_WRITE
  } tag_op_e;

  typedef enum logic [2:0] {
    MHU_IDLE,
    READ_TAG,
    SEND_DMA,
    WAIT_DMA,
    DRAIN,
    COMMIT
  } mhu_state_e;

  function automatic tag_t addr_tag(addr_t addr);
    return addr[ADDR_W-1 -: TAG_W];
  endfunction

  function automatic index_t addr_index(addr_t addr);
    return addr[BYTE_SEL_W+OFFSET_W +: INDEX_W];
  endfunction

  function automatic word_off_t addr_offset(addr_t addr);
    return addr[BYTE_SEL_W +: OFFSET_W];
  endfunction

  // Walk from the root, left on 0 and right on 1, down to a leaf
  function automatic way_t lru_leaf(lru_t lru);
    int unsigned node;
    node = 0;
    for (int lvl = 0; lvl < WAY_W; lvl++) begin
      node = 2 * node + 1 + int'(lru[node]);
    end
    return way_t'(node - (WAYS - 1));
  endfunction

  // Every bit on the path of the touched way points away from it
  function automatic lru_t lru_touch(lru_t lru, way_t way);
    lru_t bits;
    int unsigned node;
    bits = lru;
    node = 0;
    for (int lvl = 0; lvl < WAY_W; lvl++) begin
      bits[node] = ~way[WAY_W-1-lvl];
      node = 2 * node + 1 + int'(way[WAY_W-1-lvl]);
    end
    return bits;
  endfunction

endpackage

// File: rtl/tag_stat_if.sv
// ==============================
// Read data is valid one cycle after read_v; update and read never share a cycle
// ==============================
`timescale 1ns/1ns

interface tag_stat_if;

  // Read request and the registered set read-out
  logic read_v;
  mhu_pkg::index_t read_index;
  mhu_pkg::tag_t [mhu_pkg::WAYS-1:0] read_tags;
  mhu_pkg::way_mask_t read_valid;
  mhu_pkg::way_mask_t read_dirty;
  mhu_pkg::lru_t read_lru;

  // One-way update, also touches the way in the LRU tree
  logic upd_v;
  mhu_pkg::index_t upd_index;
  mhu_pkg::way_t upd_way;
  mhu_pkg::tag_t upd_tag;
  logic upd_dirty;

  modport fsm (
    output read_v, read_index,
    input read_tags, read_valid, read_dirty, read_lru,
    output upd_v, upd_index, upd_way, upd_tag, upd_dirty
  );

  modport store (
    input read_v, read_index,
    output read_tags, read_valid, read_dirty, read_lru,
    input upd_v, upd_index, upd_way, upd_tag, upd_dirty
  );

endinterface

// File: rtl/miss_queue.sv
// ==============================
// QUEUE_DEPTH must be a power of two; push only when not full
// ==============================
`timescale 1ns/1ns

module miss_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            push_i,
  input  mhu_pkg::id_t    push_id_i,
  input  mhu_pkg::addr_t  push_addr_i,
  input  logic            push_write_i,
  input  mhu_pkg::data_t  push_data_i,
  output logic            full_o,
  output logic            head_v_o,
  output mhu_pkg::id_t    head_id_o,
  output mhu_pkg::addr_t  head_addr_o,
  output logic            head_write_o,
  output mhu_pkg::data_t  head_data_o,
  input  logic            pop_i
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  mhu_pkg::id_t id_q [QUEUE_DEPTH];
  mhu_pkg::addr_t addr_q [QUEUE_DEPTH];
  logic write_q [QUEUE_DEPTH];
  mhu_pkg::data_t data_q [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W:0] count_r;

  assign full_o = (count_r == (PTR_W + 1)'(QUEUE_DEPTH));
  assign head_v_o = (count_r != '0);

  assign head_id_o = id_q[rd_ptr_r];
  assign head_addr_o = addr_q[rd_ptr_r];
  assign head_write_o = write_q[rd_ptr_r];
  assign head_data_o = data_q[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[wr_ptr_r] <= push_id_i;
      addr_q[wr_ptr_r] <= push_addr_i;
      write_q[wr_ptr_r] <= push_write_i;
      data_q[wr_ptr_r] <= push_data_i;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10: count_r <= count_r + 1'b1;
        2'b01: count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  no_overrun: assert property (@(posedge clk_i) disable iff (reset_i)
    !(push_i && full_o) && !(pop_i && !head_v_o))
    else $error("miss queue pushed while full or popped while empty");

endmodule

// File: rtl/tag_stat_store.sv
// ==============================
// Registered read of a whole set; an update lands the cycle after upd_v
// ==============================
`timescale 1ns/1ns

module tag_stat_store (
  input logic clk_i,
  input logic reset_i,
  tag_stat_if.store ts
);

  // Tags per set, all ways packed side by side
  mhu_pkg::tag_t [mhu_pkg::WAYS-1:0] tags_r [mhu_pkg::SETS];
  mhu_pkg::way_mask_t valid_r [mhu_pkg::SETS];
  mhu_pkg::way_mask_t dirty_r [mhu_pkg::SETS];
  mhu_pkg::lru_t lru_r [mhu_pkg::SETS];

  mhu_pkg::tag_op_e op;

  // Update wins if both were ever raised together
  always_comb begin
    if (ts.upd_v) begin
      op = mhu_pkg::TAG_OP_WRITE;
    end else if (ts.read_v) begin
      op = mhu_pkg::TAG_OP_READ;
    end else begin
      op = mhu_pkg::TAG_OP_IDLE;
    end
  end

  // Status bits
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < mhu_pkg::SETS; s++) begin
        valid_r[s] <= '0;
        dirty_r[s] <= '0;
        lru_r[s] <= '0;
      end
    end else if (op == mhu_pkg::TAG_OP_WRITE) begin
      valid_r[ts.upd_index][ts.upd_way] <= 1'b1;
      dirty_r[ts.upd_index][ts.upd_way] <= ts.upd_dirty;
      lru_r[ts.upd_index] <= mhu_pkg::lru_touch(lru_r[ts.upd_index], ts.upd_way);
    end
  end

  // Tag array and read-out registers
  always_ff @(posedge clk_i) begin
    case (op)
      mhu_pkg::TAG_OP_READ: begin
        ts.read_tags <= tags_r[ts.read_index];
        ts.read_valid <= valid_r[ts.read_index];
        ts.read_dirty <= dirty_r[ts.read_index];
        ts.read_lru <= lru_r[ts.read_index];
      end
      mhu_pkg::TAG_OP_WRITE: begin
        tags_r[ts.upd_index][ts.upd_way] <= ts.upd_tag;
      end
      default: begin
        // Read-out holds its last value
      end
    endcase
  end

  read_upd_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(ts.read_v && ts.upd_v))
    else $error("tag store got a read and an update in the same cycle");

endmodule

// File: rtl/victim_select.sv
// ==============================
// Purely combinational; inputs are one set's registered read-out
// ==============================
`timescale 1ns/1ns

module victim_select (
  input  mhu_pkg::tag_t [mhu_pkg::WAYS-1:0] tags_i,
  input  mhu_pkg::way_mask_t                valid_i,
  input  mhu_pkg::way_mask_t                dirty_i,
  input  mhu_pkg::lru_t                     lru_i,
  input  mhu_pkg::tag_t                     req_tag_i,
  output logic                              hit_o,
  output mhu_pkg::way_t                     hit_way_o,
  output mhu_pkg::way_t                     victim_way_o,
  output logic                              evict_o,
  output mhu_pkg::tag_t                     evict_tag_o
);

  logic inv_found;
  mhu_pkg::way_t inv_way;

  // At most one valid way can match the tag
  always_comb begin
    hit_o = 1'b0;
    hit_way_o = '0;
    for (int w = 0; w < mhu_pkg::WAYS; w++) begin
      if (valid_i[w] && (tags_i[w] == req_tag_i)) begin
        hit_o = 1'b1;
        hit_way_o = mhu_pkg::way_t'(w);
      end
    end
  end

  // Scan downwards so the lowest invalid way is kept
  always_comb begin
    inv_found = 1'b0;
    inv_way = '0;
    for (int w = mhu_pkg::WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_found = 1'b1;
        inv_way = mhu_pkg::way_t'(w);
      end
    end
  end

  assign victim_way_o = inv_found ? inv_way : mhu_pkg::lru_leaf(lru_i);

  // Write-back needed only for a valid dirty victim
  assign evict_o = valid_i[victim_way_o] & dirty_i[victim_way_o];
  assign evict_tag_o = tags_i[victim_way_o];

endmodule

// File: rtl/miss_fsm.sv
// ==============================
// One DMA in flight at a time; dma_done_i is held until dma_ack_o
// ==============================
`timescale 1ns/1ns

module miss_fsm (
  input  logic                  clk_i,
  input  logic                  reset_i,
  tag_stat_if.fsm               ts,
  input  logic                  head_v_i,
  input  mhu_pkg::id_t          head_id_i,
  input  mhu_pkg::addr_t        head_addr_i,
  input  logic                  head_write_i,
  input  mhu_pkg::data_t        head_data_i,
  output logic                  pop_o,
  input  logic                  hit_i,
  input  mhu_pkg::way_t         hit_way_i,
  input  mhu_pkg::way_t         victim_way_i,
  input  logic                  evict_i,
  input  mhu_pkg::tag_t         evict_tag_i,
  output mhu_pkg::tag_t         req_tag_o,
  output logic                  dma_cmd_v_o,
  output mhu_pkg::way_t         dma_way_o,
  output mhu_pkg::index_t       dma_index_o,
  output mhu_pkg::tag_t         dma_refill_tag_o,
  output logic                  dma_evict_o,
  output mhu_pkg::tag_t         dma_evict_tag_o,
  input  logic                  dma_done_i,
  output logic                  dma_ack_o,
  output logic                  data_v_o,
  output mhu_pkg::way_t         data_way_o,
  output mhu_pkg::index_t       data_index_o,
  output mhu_pkg::word_off_t    data_offset_o,
  output logic                  data_write_o,
  output mhu_pkg::data_t        data_wdata_o,
  output mhu_pkg::id_t          data_id_o,
  input  logic                  data_yumi_i,
  output logic                  idle_o,
  input  logic                  queue_empty_i
);

  mhu_pkg::mhu_state_e state_r;
  mhu_pkg::mhu_state_e state_n;

  // Block currently being handled
  mhu_pkg::tag_t cur_tag_r;
  mhu_pkg::index_t cur_index_r;
  mhu_pkg::way_t cur_way_r;
  logic evict_r;
  mhu_pkg::tag_t evict_tag_r;
  // Old dirty bit kept when the block was already present
  logic keep_dirty_r;
  // Set once any drained miss was a store
  logic store_r;

  logic same_block;

  assign same_block = head_v_i
    && (mhu_pkg::addr_tag(head_addr_i) == cur_tag_r)
    && (mhu_pkg::addr_index(head_addr_i) == cur_index_r);

  always_comb begin
    state_n = state_r;
    case (state_r)
      mhu_pkg::MHU_IDLE: if (head_v_i) state_n = mhu_pkg::READ_TAG;
      mhu_pkg::READ_TAG: state_n = hit_i ? mhu_pkg::DRAIN : mhu_pkg::SEND_DMA;
      mhu_pkg::SEND_DMA: state_n = mhu_pkg::WAIT_DMA;
      mhu_pkg::WAIT_DMA: if (dma_done_i) state_n = mhu_pkg::DRAIN;
      mhu_pkg::DRAIN: if (!same_block) state_n = mhu_pkg::COMMIT;
      mhu_pkg::COMMIT: state_n = mhu_pkg::MHU_IDLE;
      default: state_n = mhu_pkg::MHU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= mhu_pkg::MHU_IDLE;
      store_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (state_r == mhu_pkg::READ_TAG) begin
        store_r <= 1'b0;
      end else if (pop_o && head_write_i) begin
        store_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == mhu_pkg::MHU_IDLE) begin
      cur_tag_r <= mhu_pkg::addr_tag(head_addr_i);
      cur_index_r <= mhu_pkg::addr_index(head_addr_i);
    end
    if (state_r == mhu_pkg::READ_TAG) begin
      cur_way_r <= hit_i ? hit_way_i : victim_way_i;
      evict_r <= evict_i;
      evict_tag_r <= evict_tag_i;
      keep_dirty_r <= hit_i & ts.read_dirty[hit_way_i];
    end
  end

  // Set lookup issued from idle, result seen in READ_TAG
  assign ts.read_v = (state_r == mhu_pkg::MHU_IDLE) && head_v_i;
  assign ts.read_index = mhu_pkg::addr_index(head_addr_i);
  assign req_tag_o = cur_tag_r;

  assign dma_cmd_v_o = (state_r == mhu_pkg::SEND_DMA);
  assign dma_way_o = cur_way_r;
  assign dma_index_o = cur_index_r;
  assign dma_refill_tag_o = cur_tag_r;
  assign dma_evict_o = evict_r;
  assign dma_evict_tag_o = evict_tag_r;
  assign dma_ack_o = (state_r == mhu_pkg::WAIT_DMA) && dma_done_i;

  // Packet fields come from the queue head, stable until it is popped
  assign data_v_o = (state_r == mhu_pkg::DRAIN) && same_block;
  assign data_way_o = cur_way_r;
  assign data_index_o = cur_index_r;
  assign data_offset_o = mhu_pkg::addr_offset(head_addr_i);
  assign data_write_o = head_write_i;
  assign data_wdata_o = head_data_i;
  assign data_id_o = head_id_i;
  assign pop_o = data_v_o && data_yumi_i;

  assign ts.upd_v = (state_r == mhu_pkg::COMMIT);
  assign ts.upd_index = cur_index_r;
  assign ts.upd_way = cur_way_r;
  assign ts.upd_tag = cur_tag_r;
  assign ts.upd_dirty = store_r | keep_dirty_r;

  assign idle_o = (state_r == mhu_pkg::MHU_IDLE) && queue_empty_i;

  // A new command never goes out while the previous one is still unacknowledged
  dma_cmd_in_send: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_cmd_v_o |-> !dma_done_i)
    else $error("DMA command sent with a done still pending");

endmodule

// File: rtl/miss_handler.sv
// ==============================
// A miss is taken when miss_v_i and miss_ready_o are both high
// ==============================
`timescale 1ns/1ns

module miss_handler #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                miss_v_i,
  output logic                miss_ready_o,
  input  mhu_pkg::id_t        miss_id_i,
  input  mhu_pkg::addr_t      miss_addr_i,
  input  logic                miss_write_i,
  input  mhu_pkg::data_t      miss_data_i,
  output logic                dma_cmd_v_o,
  output mhu_pkg::way_t       dma_way_o,
  output mhu_pkg::index_t     dma_index_o,
  output mhu_pkg::tag_t       dma_refill_tag_o,
  output logic                dma_evict_o,
  output mhu_pkg::tag_t       dma_evict_tag_o,
  input  logic                dma_done_i,
  output logic                dma_ack_o,
  output logic                data_v_o,
  output mhu_pkg::way_t       data_way_o,
  output mhu_pkg::index_t     data_index_o,
  output mhu_pkg::word_off_t  data_offset_o,
  output logic                data_write_o,
  output mhu_pkg::data_t      data_wdata_o,
  output mhu_pkg::id_t        data_id_o,
  input  logic                data_yumi_i,
  output logic                idle_o
);

  logic queue_full;
  logic head_v;
  mhu_pkg::id_t head_id;
  mhu_pkg::addr_t head_addr;
  logic head_write;
  mhu_pkg::data_t head_data;
  logic pop;

  logic hit;
  mhu_pkg::way_t hit_way;
  mhu_pkg::way_t victim_way;
  logic evict;
  mhu_pkg::tag_t evict_tag;
  mhu_pkg::tag_t req_tag;

  assign miss_ready_o = ~queue_full;

  tag_stat_if ts_if ();

  miss_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) miss_queue_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_i       (miss_v_i & miss_ready_o),
    .push_id_i    (miss_id_i),
    .push_addr_i  (miss_addr_i),
    .push_write_i (miss_write_i),
    .push_data_i  (miss_data_i),
    .full_o       (queue_full),
    .head_v_o     (head_v),
    .head_id_o    (head_id),
    .head_addr_o  (head_addr),
    .head_write_o (head_write),
    .head_data_o  (head_data),
    .pop_i        (pop)
  );

  tag_stat_store tag_stat_store_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ts      (ts_if.store)
  );

  victim_select victim_select_inst (
    .tags_i       (ts_if.read_tags),
    .valid_i      (ts_if.read_valid),
    .dirty_i      (ts_if.read_dirty),
    .lru_i        (ts_if.read_lru),
    .req_tag_i    (req_tag),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way),
    .evict_o      (evict),
    .evict_tag_o  (evict_tag)
  );

  miss_fsm miss_fsm_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .ts               (ts_if.fsm),
    .head_v_i         (head_v),
    .head_id_i        (head_id),
    .head_addr_i      (head_addr),
    .head_write_i     (head_write),
    .head_data_i      (head_data),
    .pop_o            (pop),
    .hit_i            (hit),
    .hit_way_i        (hit_way),
    .victim_way_i     (victim_way),
    .evict_i          (evict),
    .evict_tag_i      (evict_tag),
    .req_tag_o        (req_tag),
    .dma_cmd_v_o      (dma_cmd_v_o),
    .dma_way_o        (dma_way_o),
    .dma_index_o      (dma_index_o),
    .dma_refill_tag_o (dma_refill_tag_o),
    .dma_evict_o      (dma_evict_o),
    .dma_evict_tag_o  (dma_evict_tag_o),
    .dma_done_i       (dma_done_i),
    .dma_ack_o        (dma_ack_o),
    .data_v_o         (data_v_o),
    .data_way_o       (data_way_o),
    .data_index_o     (data_index_o),
    .data_offset_o    (data_offset_o),
    .data_write_o     (data_write_o),
    .data_wdata_o     (data_wdata_o),
    .data_id_o        (data_id_o),
    .data_yumi_i      (data_yumi_i),
    .idle_o           (idle_o),
    .queue_empty_i    (~head_v)
  );

endmodule

// File: tb/cache_model.svh
// ==============================
// Reference tags, dirty bits and tree LRU; misses applied in acceptance order
// ==============================
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

typedef struct packed {
  mhu_pkg::way_t   way;
  mhu_pkg::index_t index;
  mhu_pkg::tag_t   refill_tag;
  logic            evict;
  mhu_pkg::tag_t   evict_tag;
} dma_cmd_t;

typedef struct packed {
  mhu_pkg::way_t      way;
  mhu_pkg::index_t    index;
  mhu_pkg::word_off_t offset;
  logic               write;
  mhu_pkg::data_t     wdata;
  mhu_pkg::id_t       id;
} data_pkt_t;

localparam int SET_SHIFT = mhu_pkg::BYTE_SEL_W + mhu_pkg::OFFSET_W;

mhu_pkg::tag_t model_tag [mhu_pkg::SETS][mhu_pkg::WAYS];
bit model_valid [mhu_pkg::SETS][mhu_pkg::WAYS];
bit model_dirty [mhu_pkg::SETS][mhu_pkg::WAYS];
bit model_plru [mhu_pkg::SETS][mhu_pkg::WAYS-1];
dma_cmd_t exp_dma_q[$];
data_pkt_t exp_data_q[$];

function automatic void model_reset();
  for (int s = 0; s < mhu_pkg::SETS; s++) begin
    for (int w = 0; w < mhu_pkg::WAYS; w++) begin
      model_valid[s][w] = 1'b0;
      model_dirty[s][w] = 1'b0;
    end
    for (int b = 0; b < mhu_pkg::WAYS - 1; b++) begin
      model_plru[s][b] = 1'b0;
    end
  end
  exp_dma_q.delete();
  exp_data_q.delete();
endfunction

// Follow the tree bits down to a leaf node, then map it to a way
function automatic int plru_victim(int set);
  int node;
  node = 0;
  while (node < mhu_pkg::WAYS - 1) begin
    if (model_plru[set][node]) begin
      node = 2 * node + 2;
    end else begin
      node = 2 * node + 1;
    end
  end
  return node - (mhu_pkg::WAYS - 1);
endfunction

// Climb from the leaf, each parent points to the other child
function automatic void plru_touch(int set, int way);
  int node;
  int parent;
  node = way + mhu_pkg::WAYS - 1;
  while (node > 0) begin
    parent = (node - 1) / 2;
    model_plru[set][parent] = (node % 2 == 1);
    node = parent;
  end
endfunction

function automatic void model_accept(mhu_pkg::id_t id, mhu_pkg::addr_t addr, logic write,
                                     mhu_pkg::data_t data);
  int set;
  int way;
  mhu_pkg::tag_t tag;
  dma_cmd_t cmd;
  data_pkt_t pkt;
  tag = mhu_pkg::tag_t'(addr >> (mhu_pkg::ADDR_W - mhu_pkg::TAG_W));
  set = int'((addr >> SET_SHIFT) % mhu_pkg::SETS);
  way = -1;
  for (int w = 0; w < mhu_pkg::WAYS; w++) begin
    if (model_valid[set][w] && model_tag[set][w] == tag) begin
      way = w;
    end
  end
  if (way >= 0) begin
    model_dirty[set][way] = model_dirty[set][way] | write;
  end else begin
    for (int w = mhu_pkg::WAYS - 1; w >= 0; w--) begin
      if (!model_valid[set][w]) begin
        way = w;
      end
    end
    if (way < 0) begin
      way = plru_victim(set);
    end
    cmd.way = mhu_pkg::way_t'(way);
    cmd.index = mhu_pkg::index_t'(set);
    cmd.refill_tag = tag;
    cmd.evict = model_valid[set][way] && model_dirty[set][way];
    cmd.evict_tag = model_tag[set][way];
    exp_dma_q.push_back(cmd);
    model_tag[set][way] = tag;
    model_valid[set][way] = 1'b1;
    model_dirty[set][way] = write;
  end
  plru_touch(set, way);
  pkt.way = mhu_pkg::way_t'(way);
  pkt.index = mhu_pkg::index_t'(set);
  pkt.offset = mhu_pkg::word_off_t'(addr >> mhu_pkg::BYTE_SEL_W);
  pkt.write = write;
  pkt.wdata = data;
  pkt.id = id;
  exp_data_q.push_back(pkt);
endfunction

`endif

// File: tb/miss_handler_tb.sv
// ==============================
// Random misses on a few sets and a small tag pool, checked against a model
// ==============================
`timescale 1ns/1ns

module miss_handler_tb;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_MISSES = 400;
  localparam int MAX_DMA_DELAY = 12;
  // Lookup, command, longest DMA, ack, commit, plus stalls and stimulus gaps
  localparam int PER_MISS_CYCLES = MAX_DMA_DELAY + 24;
  localparam int WATCHDOG_NS = (NUM_MISSES * PER_MISS_CYCLES + 20) * CLK_PERIOD;

`include "cache_model.svh"

  logic clk_i = 1'b0;
  logic reset_i;
  logic miss_v_i;
  logic miss_ready_o;
  mhu_pkg::id_t miss_id_i;
  mhu_pkg::addr_t miss_addr_i;
  logic miss_write_i;
  mhu_pkg::data_t miss_data_i;
  logic dma_cmd_v_o;
  mhu_pkg::way_t dma_way_o;
  mhu_pkg::index_t dma_index_o;
  mhu_pkg::tag_t dma_refill_tag_o;
  logic dma_evict_o;
  mhu_pkg::tag_t dma_evict_tag_o;
  logic dma_done_i;
  logic dma_ack_o;
  logic data_v_o;
  mhu_pkg::way_t data_way_o;
  mhu_pkg::index_t data_index_o;
  mhu_pkg::word_off_t data_offset_o;
  logic data_write_o;
  mhu_pkg::data_t data_wdata_o;
  mhu_pkg::id_t data_id_o;
  logic data_yumi_i;
  logic idle_o;

  logic yumi_en;
  logic stall_pending = 1'b0;
  logic drained = 1'b0;
  data_pkt_t held_pkt;
  int dma_count = 0;
  int pkt_count = 0;

  // Consumer only answers while a packet is offered
  assign data_yumi_i = data_v_o & yumi_en;

  miss_handler #(
    .QUEUE_DEPTH(8)
  ) miss_handler_inst (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic end_with_failure(string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] got);
    end_with_failure($sformatf("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h",
                               $time, name, exp, got));
  endtask

  task automatic check_dma_cmd(dma_cmd_t exp, dma_cmd_t got);
    if (got.way !== exp.way) report_mismatch("dma_way_o", 64'(exp.way), 64'(got.way));
    else if (got.index !== exp.index)
      report_mismatch("dma_index_o", 64'(exp.index), 64'(got.index));
    else if (got.refill_tag !== exp.refill_tag)
      report_mismatch("dma_refill_tag_o", 64'(exp.refill_tag), 64'(got.refill_tag));
    else if (got.evict !== exp.evict)
      report_mismatch("dma_evict_o", 64'(exp.evict), 64'(got.evict));
    else if (exp.evict && got.evict_tag !== exp.evict_tag)
      report_mismatch("dma_evict_tag_o", 64'(exp.evict_tag), 64'(got.evict_tag));
  endtask

  task automatic check_data_pkt(data_pkt_t exp, data_pkt_t got);
    if (got.way !== exp.way) report_mismatch("data_way_o", 64'(exp.way), 64'(got.way));
    else if (got.index !== exp.index)
      report_mismatch("data_index_o", 64'(exp.index), 64'(got.index));
    else if (got.offset !== exp.offset)
      report_mismatch("data_offset_o", 64'(exp.offset), 64'(got.offset));
    else if (got.write !== exp.write)
      report_mismatch("data_write_o", 64'(exp.write), 64'(got.write));
    else if (got.wdata !== exp.wdata)
      report_mismatch("data_wdata_o", 64'(exp.wdata), 64'(got.wdata));
    else if (got.id !== exp.id)
      report_mismatch("data_id_o", 64'(exp.id), 64'(got.id));
  endtask

  task automatic check_quiet(string when);
    if (idle_o !== 1'b1) end_with_failure({"idle_o is not high ", when});
    else if (miss_ready_o !== 1'b1) end_with_failure({"miss_ready_o is not high ", when});
    else if (dma_cmd_v_o !== 1'b0) end_with_failure({"dma_cmd_v_o is not low ", when});
    else if (dma_ack_o !== 1'b0) end_with_failure({"dma_ack_o is not low ", when});
    else if (data_v_o !== 1'b0) end_with_failure({"data_v_o is not low ", when});
  endtask

  function automatic dma_cmd_t seen_dma();
    return '{dma_way_o, dma_index_o, dma_refill_tag_o, dma_evict_o, dma_evict_tag_o};
  endfunction

  function automatic data_pkt_t seen_pkt();
    return '{data_way_o, data_index_o, data_offset_o, data_write_o, data_wdata_o, data_id_o};
  endfunction

  // Everything settles by the falling edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (stall_pending) begin
        if (data_v_o !== 1'b1) end_with_failure("data_v_o dropped before its packet was taken");
        else check_data_pkt(held_pkt, seen_pkt());
      end
      if (dma_cmd_v_o === 1'b1) begin
        if (exp_dma_q.size() == 0) end_with_failure("DMA command for a block already present");
        else check_dma_cmd(exp_dma_q.pop_front(), seen_dma());
        dma_count++;
      end
      if (data_v_o === 1'b1 && data_yumi_i === 1'b1) begin
        if (exp_data_q.size() == 0) end_with_failure("Data packet with no miss left to serve");
        else check_data_pkt(exp_data_q.pop_front(), seen_pkt());
        pkt_count++;
      end
      stall_pending = (data_v_o === 1'b1) && !data_yumi_i;
      held_pkt = seen_pkt();
      if (miss_v_i && miss_ready_o === 1'b1) begin
        model_accept(miss_id_i, miss_addr_i, miss_write_i, miss_data_i);
      end
      drained = (idle_o === 1'b1) && !dma_done_i
        && exp_dma_q.size() == 0 && exp_data_q.size() == 0;
    end
  end

  always @(posedge clk_i) begin
    yumi_en <= ($urandom_range(0, 3) != 0);
  end

  // DMA engine raises done after a random delay and holds it until acknowledged
  initial begin
    int delay;
    forever begin
      @(negedge clk_i);
      if (dma_cmd_v_o === 1'b1) begin
        delay = $urandom_range(1, MAX_DMA_DELAY);
        repeat (delay) @(posedge clk_i);
        dma_done_i <= 1'b1;
        do @(negedge clk_i); while (dma_ack_o !== 1'b1);
        @(posedge clk_i);
        dma_done_i <= 1'b0;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    end_with_failure("Watchdog expired before all misses were handled");
  end

  initial begin
    int gap;
    mhu_pkg::tag_t cur_tag;
    mhu_pkg::index_t cur_index;
    void'($urandom(59075));
    reset_i <= 1'b1;
    miss_v_i <= 1'b0;
    miss_id_i <= '0;
    miss_addr_i <= '0;
    miss_write_i <= 1'b0;
    miss_data_i <= '0;
    dma_done_i <= 1'b0;
    yumi_en <= 1'b0;
    cur_tag = '0;
    cur_index = '0;
    model_reset();
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_quiet("after reset");
    @(posedge clk_i);
    for (int n = 0; n < NUM_MISSES; n++) begin
      gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 6) : 0;
      if (gap > 0) begin
        miss_v_i <= 1'b0;
        repeat (gap) @(posedge clk_i);
      end
      // Often stay on the last block so secondary misses and hits appear
      if (n == 0 || $urandom_range(0, 2) != 0) begin
        cur_tag = mhu_pkg::tag_t'(8 + $urandom_range(0, 5));
        cur_index = ($urandom_range(0, 1) == 1) ? mhu_pkg::index_t'(3) : mhu_pkg::index_t'(12);
      end
      miss_v_i <= 1'b1;
      miss_id_i <= mhu_pkg::id_t'(n);
      miss_addr_i <= {cur_tag, cur_index, mhu_pkg::word_off_t'($urandom_range(0, 3)),
                      {mhu_pkg::BYTE_SEL_W{1'b0}}};
      miss_write_i <= 1'($urandom_range(0, 1));
      miss_data_i <= mhu_pkg::data_t'($urandom());
      do @(negedge clk_i); while (miss_ready_o !== 1'b1);
      @(posedge clk_i);
    end
    miss_v_i <= 1'b0;
    do @(posedge clk_i); while (!drained);
    check_quiet("after all traffic");
    $display("%0d misses, %0d DMA commands, %0d packets", NUM_MISSES, dma_count, pkt_count);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: build.f
+incdir+tb
rtl/mhu_pkg.sv
rtl/tag_stat_if.sv
rtl/miss_queue.sv
rtl/tag_stat_store.sv
rtl/victim_select.sv
rtl/miss_fsm.sv
rtl/miss_handler.sv
tb/miss_handler_tb.sv

// File: Makefile
# Verilator build and run of the miss handler testbench

VERILATOR ?= verilator
TOP       ?= miss_handler_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       ?= ./$(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$($(SIM) 2>&1); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
